//--- mni_pkg.sv
package mni_pkg;

  // ======================================
  // data path widths
  // ======================================

  // one operation word as written by the cpu
  localparam int WORD_W = 16;

  // virtual channels on the network-out port
  localparam int NUM_VC = 3;

  // word offset inside one packet
  localparam int OFFSET_W = 6;

  // ======================================
  // operation fifo sizing
  // ======================================

  // distributed memory, in words
  localparam int OP_FIFO_DEPTH = 64;
  localparam int OP_FIFO_ADR_W = 6;

  // complete operations held
  localparam int OP_PKTS_W = 6;

  // header plus 31 payload words
  localparam int OP_MAX_WORDS = 32;

  // ======================================
  // operation header fields
  // ======================================

  // target vc, 3 is not a channel
  localparam int HDR_VC_MSB = 15;
  localparam int HDR_VC_LSB = 14;

  // source node, replaced on the way out
  localparam int HDR_NODE_MSB = 9;
  localparam int HDR_NODE_LSB = 6;

  // payload words, packet is one longer
  localparam int HDR_LEN_MSB = 5;
  localparam int HDR_LEN_LSB = 0;

  // ======================================
  // shared types
  // ======================================

  typedef logic [WORD_W-1:0] word_t;

  // one bit per vc, one-hot when used as enq
  typedef logic [NUM_VC-1:0] vc_mask_t;

endpackage

//--- mni_op_fifo.sv
`timescale 1ns/1ps

module mni_op_fifo import mni_pkg::*; (
  input  logic                 clk_ni,
  input  logic                 i_reset,

  // write side, cpu operation words
  input  word_t                i_wr_data,
  input  logic                 i_wr_en,
  output logic                 o_full,
  output logic [OP_PKTS_W-1:0] o_wr_packets,

  // read side, packet at a time
  output word_t                o_rd_data,
  input  logic [OFFSET_W-1:0]  i_rd_offset,
  input  logic                 i_rd_eop,
  output logic                 o_empty
);

  // ======================================
  // storage and pointers
  // ======================================

  word_t mem [OP_FIFO_DEPTH];

  logic [OP_FIFO_ADR_W-1:0] wr_ptr;
  logic [OP_FIFO_ADR_W-1:0] base_ptr;
  logic [OP_FIFO_ADR_W-1:0] rd_adr;

  // needs one extra bit, 0 to 64 free words
  logic [OP_FIFO_ADR_W:0]   free_cnt;
  logic [OP_FIFO_ADR_W:0]   freed_words;

  // payload words still to come, 0 means next word is a header
  logic [OFFSET_W-1:0]      wr_left;
  logic [OFFSET_W-1:0]      hdr_len;

  logic                     wr_accept;
  logic                     wr_is_hdr;
  logic                     wr_last;

  // ======================================
  // write side
  // ======================================

  // stall already tells the source to hold
  assign wr_accept = i_wr_en & ~o_full;

  assign wr_is_hdr = (wr_left == '0);
  assign hdr_len   = OFFSET_W'(i_wr_data[HDR_LEN_MSB:HDR_LEN_LSB]);

  // last word of an operation
  // header-only op ends on its header
  assign wr_last = wr_accept &
                   (wr_is_hdr ? (hdr_len == '0) : (wr_left == OFFSET_W'(1)));

  always_ff @(posedge clk_ni) begin
    if (wr_accept) begin
      mem[wr_ptr] <= i_wr_data;
    end
  end

  always_ff @(posedge clk_ni) begin
    if (i_reset) begin
      wr_ptr  <= '0;
      wr_left <= '0;
    end else if (wr_accept) begin
      wr_ptr <= wr_ptr + 1'b1;
      // load length from header, then count payload down
      if (wr_is_hdr) begin
        wr_left <= hdr_len;
      end else begin
        wr_left <= wr_left - 1'b1;
      end
    end
  end

  // ======================================
  // read side
  // ======================================

  // offset is relative to the head packet
  assign rd_adr    = base_ptr + OP_FIFO_ADR_W'(i_rd_offset);
  assign o_rd_data = mem[rd_adr];

  // eop frees the whole head packet
  assign freed_words = (OP_FIFO_ADR_W+1)'(i_rd_offset) + 1'b1;

  always_ff @(posedge clk_ni) begin
    if (i_reset) begin
      base_ptr <= '0;
    end else if (i_rd_eop) begin
      base_ptr <= base_ptr + OP_FIFO_ADR_W'(freed_words);
    end
  end

  // ======================================
  // occupancy
  // ======================================

  always_ff @(posedge clk_ni) begin
    if (i_reset) begin
      free_cnt <= (OP_FIFO_ADR_W+1)'(OP_FIFO_DEPTH);
    end else begin
      case ({wr_accept, i_rd_eop})
        2'b10:   free_cnt <= free_cnt - 1'b1;
        2'b01:   free_cnt <= free_cnt + freed_words;
        2'b11:   free_cnt <= free_cnt + freed_words - 1'b1;
        default: free_cnt <= free_cnt;
      endcase
    end
  end

  // complete packets only
  // up on last word written, down on eop
  always_ff @(posedge clk_ni) begin
    if (i_reset) begin
      o_wr_packets <= '0;
    end else begin
      case ({wr_last, i_rd_eop})
        2'b10:   o_wr_packets <= o_wr_packets + 1'b1;
        2'b01:   o_wr_packets <= o_wr_packets - 1'b1;
        default: o_wr_packets <= o_wr_packets;
      endcase
    end
  end

  // room for a longest operation must stay free
  assign o_full  = (free_cnt < OP_MAX_WORDS);
  assign o_empty = (o_wr_packets == '0);

endmodule

//--- mni_op_dispatch.sv
`timescale 1ns/1ps

module mni_op_dispatch import mni_pkg::*; (
  input  logic                clk_ni,
  input  logic                i_reset,

  input  logic [3:0]          i_node_id,

  // operation fifo read side
  input  word_t               i_fifo_rd_data,
  input  logic                i_fifo_empty,
  output logic [OFFSET_W-1:0] o_fifo_rd_offset,
  output logic                o_fifo_rd_eop,

  // network out
  output vc_mask_t            o_nout_enq,
  output logic [OFFSET_W-1:0] o_nout_offset,
  output logic                o_nout_eop,
  output word_t               o_nout_data,
  input  vc_mask_t            i_nout_full
);

  typedef enum logic [1:0] {
    st_idle,
    st_send,
    st_gap
  } state_t;

  state_t state;

  // ======================================
  // header decode at offset 0
  // ======================================

  logic [HDR_VC_MSB-HDR_VC_LSB:0] hdr_vc;
  logic [OFFSET_W-1:0]            hdr_len;
  vc_mask_t                       hdr_mask;
  logic                           hdr_bad;
  logic                           vc_ready;
  word_t                          hdr_stamped;

  // payload words of the op in flight
  logic [OFFSET_W-1:0]            op_len;
  logic                           last_word;

  // offset is held at 0 while idle, so this is the header
  assign hdr_vc  = i_fifo_rd_data[HDR_VC_MSB:HDR_VC_LSB];
  assign hdr_len = OFFSET_W'(i_fifo_rd_data[HDR_LEN_MSB:HDR_LEN_LSB]);

  // vc code 3 has no channel behind it
  assign hdr_bad  = (hdr_vc >= NUM_VC);
  assign hdr_mask = vc_mask_t'(1) << hdr_vc;

  // full only matters before the packet starts
  assign vc_ready = ~|(hdr_mask & i_nout_full);

  always_comb begin
    hdr_stamped = i_fifo_rd_data;
    hdr_stamped[HDR_NODE_MSB:HDR_NODE_LSB] = i_node_id;
  end

  // read offset runs one word ahead of the output offset
  assign last_word = (o_fifo_rd_offset == op_len);

  // ======================================
  // control fsm
  // ======================================

  always_ff @(posedge clk_ni) begin
    if (i_reset) begin
      state            <= st_idle;
      o_nout_enq       <= '0;
      o_nout_eop       <= 1'b0;
      o_fifo_rd_eop    <= 1'b0;
      o_fifo_rd_offset <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (!i_fifo_empty) begin
            if (hdr_bad) begin
              // drop whole op, eop with offset = len frees it
              o_fifo_rd_eop    <= 1'b1;
              o_fifo_rd_offset <= hdr_len;
              state            <= st_gap;
            end else if (vc_ready) begin
              o_nout_enq <= hdr_mask;
              if (hdr_len == '0) begin
                // header-only op, done in one word
                o_nout_eop    <= 1'b1;
                o_fifo_rd_eop <= 1'b1;
                state         <= st_gap;
              end else begin
                o_fifo_rd_offset <= OFFSET_W'(1);
                state            <= st_send;
              end
            end
          end
        end

        st_send: begin
          // enq held, one payload word per cycle
          if (last_word) begin
            o_nout_eop    <= 1'b1;
            o_fifo_rd_eop <= 1'b1;
            state         <= st_gap;
          end else begin
            o_fifo_rd_offset <= o_fifo_rd_offset + 1'b1;
          end
        end

        st_gap: begin
          // fifo takes eop this cycle
          o_nout_enq       <= '0;
          o_nout_eop       <= 1'b0;
          o_fifo_rd_eop    <= 1'b0;
          o_fifo_rd_offset <= '0;
          state            <= st_idle;
        end

        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // ======================================
  // output words
  // ======================================

  always_ff @(posedge clk_ni) begin
    case (state)
      st_idle: begin
        o_nout_offset <= '0;
        o_nout_data   <= hdr_stamped;
        op_len        <= hdr_len;
      end
      st_send: begin
        o_nout_offset <= o_fifo_rd_offset;
        o_nout_data   <= i_fifo_rd_data;
      end
      default: begin
        o_nout_offset <= o_nout_offset;
        o_nout_data   <= o_nout_data;
      end
    endcase
  end

endmodule

//--- mni_trace.sv
`timescale 1ns/1ps

module mni_trace import mni_pkg::*; (
  input  logic     clk_ni,
  input  logic     i_reset,

  // event sources
  input  logic     i_op_valid,
  input  vc_mask_t i_nout_enq,
  input  logic     i_nout_eop,

  // single-cycle pulses
  output logic     o_trace_op_local,
  output vc_mask_t o_trace_vc_out
);

  // ======================================
  // event levels
  // ======================================

  logic     op_local_d;
  logic     op_local_q;
  vc_mask_t vc_out_d;
  vc_mask_t vc_out_q;

  // a word offered on the operation port
  assign op_local_d = i_op_valid;

  // last word of a packet, per vc
  assign vc_out_d = i_nout_enq & {NUM_VC{i_nout_eop}};

  // ======================================
  // edge detect
  // ======================================

  always_ff @(posedge clk_ni) begin
    if (i_reset) begin
      op_local_q <= 1'b0;
      vc_out_q   <= '0;
    end else begin
      op_local_q <= op_local_d;
      vc_out_q   <= vc_out_d;
    end
  end

  // rising edge only
  // a held level gives one pulse
  assign o_trace_op_local = op_local_d & ~op_local_q;
  assign o_trace_vc_out   = vc_out_d & ~vc_out_q;

endmodule

//--- mni.sv
`timescale 1ns/1ps

module mni import mni_pkg::*; (
  input  logic                 clk_ni,
  input  logic                 i_reset,

  input  logic [3:0]           i_node_id,

  // cpu operation port
  input  logic                 i_ctl_op_valid,
  input  word_t                i_ctl_op_data,
  output logic                 o_ctl_op_stall,

  // complete ops waiting
  output logic [OP_PKTS_W-1:0] o_ctl_cpu_fifo_ops,

  // network out
  output vc_mask_t             o_nout_enq,
  output logic [OFFSET_W-1:0]  o_nout_offset,
  output logic                 o_nout_eop,
  output word_t                o_nout_data,
  input  vc_mask_t             i_nout_full,

  // trace
  output logic                 o_ctl_trace_op_local,
  output vc_mask_t             o_ctl_trace_vc_out
);

  // ======================================
  // fifo to dispatcher
  // ======================================

  word_t               fifo_rd_data;
  logic                fifo_empty;
  logic [OFFSET_W-1:0] fifo_rd_offset;
  logic                fifo_rd_eop;

  // cpu ops, whole packets only on the read side
  mni_op_fifo u_op_fifo (
    .clk_ni       ( clk_ni ),
    .i_reset      ( i_reset ),
    .i_wr_data    ( i_ctl_op_data ),
    .i_wr_en      ( i_ctl_op_valid ),
    .o_full       ( o_ctl_op_stall ),
    .o_wr_packets ( o_ctl_cpu_fifo_ops ),
    .o_rd_data    ( fifo_rd_data ),
    .i_rd_offset  ( fifo_rd_offset ),
    .i_rd_eop     ( fifo_rd_eop ),
    .o_empty      ( fifo_empty )
  );

  // stamps node id, streams onto one vc
  mni_op_dispatch u_dispatch (
    .clk_ni           ( clk_ni ),
    .i_reset          ( i_reset ),
    .i_node_id        ( i_node_id ),
    .i_fifo_rd_data   ( fifo_rd_data ),
    .i_fifo_empty     ( fifo_empty ),
    .o_fifo_rd_offset ( fifo_rd_offset ),
    .o_fifo_rd_eop    ( fifo_rd_eop ),
    .o_nout_enq       ( o_nout_enq ),
    .o_nout_offset    ( o_nout_offset ),
    .o_nout_eop       ( o_nout_eop ),
    .o_nout_data      ( o_nout_data ),
    .i_nout_full      ( i_nout_full )
  );

  // watches the port outputs, not internal state
  mni_trace u_trace (
    .clk_ni           ( clk_ni ),
    .i_reset          ( i_reset ),
    .i_op_valid       ( i_ctl_op_valid ),
    .i_nout_enq       ( o_nout_enq ),
    .i_nout_eop       ( o_nout_eop ),
    .o_trace_op_local ( o_ctl_trace_op_local ),
    .o_trace_vc_out   ( o_ctl_trace_vc_out )
  );

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic o_clk_ni
);

  // 100 ns period, starts low
  initial begin
    o_clk_ni = 1'b0;
    forever begin
      #50 o_clk_ni = ~o_clk_ni;
    end
  end

endmodule

//--- mni_asserts.sv
`timescale 1ns/1ps

module mni_asserts import mni_pkg::*; (
  input logic                clk_ni,
  input logic                i_reset,
  input vc_mask_t            i_nout_enq,
  input logic [OFFSET_W-1:0] i_nout_offset,
  input logic                i_nout_eop
);

  // failures so far, the testbench reads this at the end
  int fail_cnt = 0;

  // one vc per word at most
  a_enq_onehot: assert property (@(posedge clk_ni) disable iff (i_reset)
    $onehot0(i_nout_enq))
    else begin
      fail_cnt++;
      $error("nout enq has more than one vc set");
    end

  // eop marks a word, never an idle cycle
  a_eop_with_enq: assert property (@(posedge clk_ni) disable iff (i_reset)
    i_nout_eop |-> (i_nout_enq != '0))
    else begin
      fail_cnt++;
      $error("nout eop without enq");
    end

  // packet starts at offset 0
  a_first_offset: assert property (@(posedge clk_ni) disable iff (i_reset)
    $rose(|i_nout_enq) |-> (i_nout_offset == '0))
    else begin
      fail_cnt++;
      $error("nout packet does not start at offset 0");
    end

  // no gaps inside a packet, offset steps by one
  a_offset_step: assert property (@(posedge clk_ni) disable iff (i_reset)
    ((|i_nout_enq) && !i_nout_eop) |=>
      ((|i_nout_enq) && (i_nout_offset == $past(i_nout_offset) + 1'b1)))
    else begin
      fail_cnt++;
      $error("nout offset did not advance by one inside a packet");
    end

  // quiet port right after a reset cycle
  a_enq_after_reset: assert property (@(posedge clk_ni)
    i_reset |=> (i_nout_enq == '0))
    else begin
      fail_cnt++;
      $error("nout enq set in the cycle after reset");
    end

endmodule

bind mni mni_asserts u_mni_asserts (
  .clk_ni        ( clk_ni ),
  .i_reset       ( i_reset ),
  .i_nout_enq    ( o_nout_enq ),
  .i_nout_offset ( o_nout_offset ),
  .i_nout_eop    ( o_nout_eop )
);

//--- tb_mni.sv
`timescale 1ns/1ps

module tb_mni import mni_pkg::*; ();

  // ========================================
  // dut and clock
  // ========================================

  localparam int TIMEOUT = 2000;
  localparam int SLOTS   = 128;

  logic                 clk_ni;
  logic                 i_reset;
  logic [3:0]           i_node_id;
  logic                 i_ctl_op_valid;
  word_t                i_ctl_op_data;
  logic                 o_ctl_op_stall;
  logic [OP_PKTS_W-1:0] o_ctl_cpu_fifo_ops;
  vc_mask_t             o_nout_enq;
  logic [OFFSET_W-1:0]  o_nout_offset;
  logic                 o_nout_eop;
  word_t                o_nout_data;
  vc_mask_t             i_nout_full;
  logic                 o_ctl_trace_op_local;
  vc_mask_t             o_ctl_trace_vc_out;

  tb_clk_gen u_clk_gen (.o_clk_ni(clk_ni));

  mni u_dut (.*);

  // ========================================
  // scoreboard state
  // ========================================

  string test_name = "reset";
  int    errors = 0;

  // expected packets in one ring per vc
  word_t exp_words [NUM_VC][SLOTS][OP_MAX_WORDS];
  int    exp_len   [NUM_VC][SLOTS];
  int    exp_wr    [NUM_VC] = '{default: 0};
  int    exp_rd    [NUM_VC] = '{default: 0};
  int    tx_total = 0;
  int    rx_total = 0;

  // packet being collected and the last complete one
  word_t cur_pkt [OP_MAX_WORDS];
  int    cur_cnt = 0;
  int    cur_vc = 0;
  word_t rx_pkt [OP_MAX_WORDS];
  int    rx_len;
  int    rx_vc;
  event  pkt_done;

  // event counts for the trace check
  int    rx_pkts       [NUM_VC] = '{default: 0};
  int    vc_out_pulses [NUM_VC] = '{default: 0};
  int    op_local_pulses = 0;
  int    bursts = 0;
  int    wr_words = 0;

  // ========================================
  // reporting
  // ========================================

  task automatic stop_failed();
    errors++;
    $display("test failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    stop_failed();
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("error: %s, %s: expected %0h, actual %0h", test_name, what, expected, actual);
      stop_failed();
    end
  endtask

  // ========================================
  // reference model
  // ========================================

  // packet words for one op
  // none when the vc code is 3
  function automatic int expected_packet(input logic [3:0] node,
                                         input word_t op [OP_MAX_WORDS],
                                         output word_t pkt [OP_MAX_WORDS]);
    int len;
    len = int'(op[0][HDR_LEN_MSB:HDR_LEN_LSB]);
    if (op[0][HDR_VC_MSB:HDR_VC_LSB] == 2'd3) begin
      return 0;
    end
    for (int i = 0; i <= len; i++) begin
      pkt[i] = op[i];
    end
    // source node replaces whatever the cpu wrote
    pkt[0][HDR_NODE_MSB:HDR_NODE_LSB] = node;
    return len + 1;
  endfunction

  function automatic void build_op(input int vc, input int len, input bit fixed,
                                   output word_t op [OP_MAX_WORDS]);
    op[0] = '0;
    op[0][HDR_VC_MSB:HDR_VC_LSB]   = 2'(vc);
    op[0][HDR_LEN_MSB:HDR_LEN_LSB] = 6'(len);
    // spare bits and a node field that must be overwritten
    op[0][HDR_VC_LSB-1:HDR_NODE_LSB] = fixed ? 8'h3c : 8'($urandom);
    for (int i = 1; i < OP_MAX_WORDS; i++) begin
      op[i] = fixed ? word_t'(vc * 256 + i) : word_t'($urandom);
    end
  endfunction

  function automatic int vc_index(input vc_mask_t enq);
    for (int v = 0; v < NUM_VC; v++) begin
      if (enq[v]) begin
        return v;
      end
    end
    return 0;
  endfunction

  // ========================================
  // operation port driver
  // ========================================

  // called and returns on a falling edge
  task automatic write_word(input word_t w);
    int waited;
    waited = 0;
    if (!i_ctl_op_valid) begin
      bursts++;
    end
    i_ctl_op_valid = 1'b1;
    i_ctl_op_data  = w;
    // word held while stalled
    while (o_ctl_op_stall) begin
      @(negedge clk_ni);
      waited++;
      if (waited > TIMEOUT) begin
        abort_run("timeout, operation port stayed stalled");
      end
    end
    @(negedge clk_ni);
  endtask

  task automatic end_burst();
    if (i_ctl_op_valid) begin
      i_ctl_op_valid = 1'b0;
      @(negedge clk_ni);
    end
  endtask

  task automatic send_op(input word_t op [OP_MAX_WORDS]);
    word_t pkt [OP_MAX_WORDS];
    int    n;
    int    vc;
    int    slot;
    n  = expected_packet(i_node_id, op, pkt);
    vc = int'(op[0][HDR_VC_MSB:HDR_VC_LSB]);
    if (n > 0) begin
      slot = exp_wr[vc] % SLOTS;
      for (int i = 0; i < n; i++) begin
        exp_words[vc][slot][i] = pkt[i];
      end
      exp_len[vc][slot] = n;
      exp_wr[vc]++;
      tx_total++;
    end
    for (int i = 0; i <= int'(op[0][HDR_LEN_MSB:HDR_LEN_LSB]); i++) begin
      write_word(op[i]);
    end
  endtask

  // every expected packet seen and the port idle
  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while (rx_total != tx_total || o_nout_enq != '0) begin
      @(negedge clk_ni);
      cycles++;
      if (cycles > TIMEOUT) begin
        abort_run("timeout waiting for the operation fifo to drain");
      end
    end
  endtask

  // ========================================
  // monitor and compare
  // ========================================

  always @(posedge clk_ni) begin
    if (!i_reset) begin
      op_local_pulses += int'(o_ctl_trace_op_local);
      for (int v = 0; v < NUM_VC; v++) begin
        vc_out_pulses[v] += int'(o_ctl_trace_vc_out[v]);
      end
      if (i_ctl_op_valid && !o_ctl_op_stall) begin
        wr_words++;
      end
      if (o_nout_enq != '0) begin
        if (cur_cnt == 0) begin
          cur_vc = vc_index(o_nout_enq);
        end
        assert (cur_cnt < OP_MAX_WORDS)
          else abort_run("packet runs past 32 words without eop");
        check_value("vc inside packet", cur_vc, vc_index(o_nout_enq));
        check_value("word offset", cur_cnt, o_nout_offset);
        cur_pkt[cur_cnt] = o_nout_data;
        cur_cnt++;
        if (o_nout_eop) begin
          rx_pkt  = cur_pkt;
          rx_len  = cur_cnt;
          rx_vc   = cur_vc;
          cur_cnt = 0;
          -> pkt_done;
        end
      end
    end
  end

  always begin : compare_packets
    int slot;
    @(pkt_done);
    assert (exp_rd[rx_vc] != exp_wr[rx_vc])
      else abort_run($sformatf("packet on vc %0d while none was expected", rx_vc));
    slot = exp_rd[rx_vc] % SLOTS;
    check_value($sformatf("vc %0d packet length", rx_vc), exp_len[rx_vc][slot], rx_len);
    for (int i = 0; i < rx_len; i++) begin
      check_value($sformatf("vc %0d word %0d", rx_vc, i), exp_words[rx_vc][slot][i],
                  rx_pkt[i]);
    end
    check_value("header node id", i_node_id, rx_pkt[0][HDR_NODE_MSB:HDR_NODE_LSB]);
    exp_rd[rx_vc]++;
    rx_pkts[rx_vc]++;
    rx_total++;
  end

  // ========================================
  // test sequence
  // ========================================

  initial begin : run_tests
    word_t op [OP_MAX_WORDS];
    int    base;
    int    waited;
    void'($urandom(32'h6e57));
    i_reset        = 1'b1;
    i_node_id      = 4'ha;
    i_ctl_op_valid = 1'b0;
    i_ctl_op_data  = '0;
    i_nout_full    = '0;
    repeat (10) @(negedge clk_ni);
    i_reset = 1'b0;

    // state straight out of reset
    check_value("enq", 0, o_nout_enq);
    check_value("eop", 0, o_nout_eop);
    check_value("trace op local", 0, o_ctl_trace_op_local);
    check_value("trace vc out", 0, o_ctl_trace_vc_out);
    check_value("stall", 0, o_ctl_op_stall);
    check_value("ops in fifo", 0, o_ctl_cpu_fifo_ops);

    // one op per vc with lengths 3, 0 and 31
    test_name = "one op per vc";
    for (int v = 0; v < NUM_VC; v++) begin
      build_op(v, (v == 0) ? 3 : ((v == 1) ? 0 : 31), 1'b1, op);
      send_op(op);
      end_burst();
    end
    wait_drained();
    for (int v = 0; v < NUM_VC; v++) begin
      check_value($sformatf("vc %0d packets", v), 1, rx_pkts[v]);
    end

    // random vcs and lengths with random burst breaks
    test_name = "random ops";
    i_node_id = 4'h3;
    repeat (40) begin
      build_op($urandom_range(NUM_VC - 1), $urandom_range(31), 1'b0, op);
      send_op(op);
      if ($urandom_range(1) == 0) begin
        end_burst();
      end
    end
    end_burst();
    wait_drained();

    // vc 1 full holds the head op and all behind it
    test_name = "back-pressure";
    i_nout_full = 3'b010;
    build_op(1, 5, 1'b0, op);
    send_op(op);
    build_op(0, 3, 1'b0, op);
    send_op(op);
    build_op(2, 7, 1'b0, op);
    send_op(op);
    build_op(1, 2, 1'b0, op);
    send_op(op);
    end_burst();
    repeat (20) begin
      check_value("enq while vc full", 0, o_nout_enq);
      check_value("ops in fifo", 4, o_ctl_cpu_fifo_ops);
      @(negedge clk_ni);
    end
    i_nout_full = '0;
    wait_drained();

    // vc code 3 is dropped but the next op still goes out
    test_name = "invalid vc";
    build_op(3, 5, 1'b0, op);
    send_op(op);
    build_op(2, 2, 1'b0, op);
    send_op(op);
    end_burst();
    wait_drained();
    check_value("ops after drop", 0, o_ctl_cpu_fifo_ops);

    // all vcs full while 48 words are offered
    // stall rises after 33
    test_name = "fifo full";
    i_nout_full = '1;
    base = wr_words;
    fork
      begin
        for (int k = 0; k < 6; k++) begin
          build_op(k % NUM_VC, 7, 1'b0, op);
          send_op(op);
        end
        end_burst();
      end
      begin
        waited = 0;
        while (!o_ctl_op_stall) begin
          @(negedge clk_ni);
          waited++;
          if (waited > TIMEOUT) begin
            abort_run("timeout, stall never rose with all vcs full");
          end
        end
        assert (wr_words - base >= 33)
          else abort_run($sformatf("stall rose with only %0d words stored", wr_words - base));
        repeat (10) begin
          @(negedge clk_ni);
          check_value("stall while all vcs full", 1, o_ctl_op_stall);
          check_value("enq while all vcs full", 0, o_nout_enq);
        end
        i_nout_full = '0;
      end
    join
    wait_drained();

    // trace pulses over the whole run
    test_name = "trace pulses";
    for (int v = 0; v < NUM_VC; v++) begin
      check_value($sformatf("vc %0d out pulses", v), exp_wr[v], vc_out_pulses[v]);
    end
    check_value("op local pulses", bursts, op_local_pulses);
    assert (u_dut.u_mni_asserts.fail_cnt == 0)
      else abort_run("an assertion on the network-out port failed");

    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- sim.f
mni_pkg.sv
mni_op_fifo.sv
mni_op_dispatch.sv
mni_trace.sv
mni.sv
tb_clk_gen.sv
mni_asserts.sv
tb_mni.sv
